//--- hw/vit_cfg.svh
`ifndef VIT_CFG_SVH
`define VIT_CFG_SVH

//////////////////////////////
// code parameters
//////////////////////////////

// constraint length and encoder memory
`define VIT_K 7
`define VIT_NU 6

// generator taps, 171 and 133 octal
`define VIT_G0 7'o171
`define VIT_G1 7'o133

//////////////////////////////
// trellis and frame sizes
//////////////////////////////

// 2**nu trellis states
`define VIT_STATES 64

// info bits per frame, plus nu zero tail bits
`define VIT_INFO_LEN 32
`define VIT_INFO_LOG 5
`define VIT_FRAME_LEN 38
`define VIT_FRAME_LOG 6

// path metric width, max metric in a frame is 76
`define VIT_PM_W 8

`endif

//--- hw/vit_pkg.sv
`include "vit_cfg.svh"

package vit_pkg;

	//////////////////////////////
	// datapath types
	//////////////////////////////

	// received symbol, bit 1 from g0 and bit 0 from g1
	typedef logic [1:0] sym_t;
	// hamming distance, 0 to 2
	typedef logic [1:0] dist_t;
	typedef logic [`VIT_PM_W-1:0] pm_t;
	typedef logic [`VIT_NU-1:0] state_t;
	// one survivor decision per state, 1 = p1 won
	typedef logic [`VIT_STATES-1:0] dec_vec_t;
	// symbol position within a frame
	typedef logic [`VIT_FRAME_LOG-1:0] sym_idx_t;

	// traceback fsm
	typedef enum logic [1:0] {
		TB_COLLECT,
		TB_TRACE,
		TB_EMIT
	} tb_state_e;

	// encoder output for one transition
	// register is new bit followed by the old state
	function automatic sym_t expected_sym(input state_t prev, input logic in_bit);
		logic [`VIT_K-1:0] enc_reg;
		enc_reg = {in_bit, prev};
		return {^(enc_reg & `VIT_G0), ^(enc_reg & `VIT_G1)};
	endfunction

endpackage

//--- hw/branch_metric.sv
`timescale 1ns/1ps
`include "vit_cfg.svh"

module branch_metric import vit_pkg::*; (
	input  logic     clk,
	input  logic     frame_rst,
	input  logic     in_valid,
	input  logic     in_ready,
	input  sym_t     in_sym,
	output logic     bm_valid,
	output logic     bm_first,
	output dist_t    d00,
	output dist_t    d01,
	output dist_t    d10,
	output dist_t    d11
);

	localparam sym_idx_t LAST_SYM = sym_idx_t'(`VIT_FRAME_LEN - 1);

	logic     in_xfer;
	sym_idx_t sym_cnt;

	// handshake with the source
	assign in_xfer = in_valid & in_ready;

	//////////////////////////////
	// control
	//////////////////////////////

	// symbol counter, wraps at frame end
	always_ff @(posedge clk)
	begin
		if (frame_rst)
		begin
			bm_valid <= 1'b0;
			sym_cnt  <= '0;
		end
		else
		begin
			bm_valid <= in_xfer;
			if (in_xfer)
			begin
				if (sym_cnt == LAST_SYM)
					sym_cnt <= '0;
				else
					sym_cnt <= sym_cnt + sym_idx_t'(1);
			end
		end
	end

	//////////////////////////////
	// distances
	//////////////////////////////

	// one bit per mismatch against each code word
	always_ff @(posedge clk)
	begin
		if (in_xfer)
		begin
			bm_first <= (sym_cnt == '0);
			d00 <= {1'b0,  in_sym[1]} + {1'b0,  in_sym[0]};
			d01 <= {1'b0,  in_sym[1]} + {1'b0, ~in_sym[0]};
			d10 <= {1'b0, ~in_sym[1]} + {1'b0,  in_sym[0]};
			d11 <= {1'b0, ~in_sym[1]} + {1'b0, ~in_sym[0]};
		end
	end

endmodule

//--- hw/acs_array.sv
`timescale 1ns/1ps
`include "vit_cfg.svh"

module acs_array import vit_pkg::*; (
	input  logic     clk,
	input  logic     frame_rst,
	input  logic     bm_valid,
	input  logic     bm_first,
	input  dist_t    d00,
	input  dist_t    d01,
	input  dist_t    d10,
	input  dist_t    d11,
	output logic     dec_valid,
	output dec_vec_t dec
);

	// start metrics, state 0 wins over any other start
	localparam pm_t PM_ZERO  = pm_t'(0);
	localparam pm_t PM_START = pm_t'(127);

	// distance table indexed by expected symbol
	dist_t    d_tab [4];
	// metrics as read by the cells
	pm_t      pm_q   [`VIT_STATES];
	pm_t      pm_rd  [`VIT_STATES];
	pm_t      pm_nxt [`VIT_STATES];
	dec_vec_t dec_nxt;

	assign d_tab[0] = d00;
	assign d_tab[1] = d01;
	assign d_tab[2] = d10;
	assign d_tab[3] = d11;

	//////////////////////////////
	// metric read
	//////////////////////////////

	// on the first symbol of a frame the old metrics are ignored
	for (genvar gs = 0; gs < `VIT_STATES; gs++)
	begin : g_rd
		if (gs == 0)
		begin : g_zero
			assign pm_rd[gs] = bm_first ? PM_ZERO : pm_q[gs];
		end
		else
		begin : g_other
			assign pm_rd[gs] = bm_first ? PM_START : pm_q[gs];
		end
	end

	//////////////////////////////
	// acs cells
	//////////////////////////////

	for (genvar gs = 0; gs < `VIT_STATES; gs++)
	begin : g_cell
		// predecessors are low 5 bits of s plus one appended bit
		localparam int P0 = (2 * gs) % `VIT_STATES;
		localparam int P1 = P0 + 1;
		// input bit is the top bit of s
		localparam logic IN_B = (gs >= `VIT_STATES / 2);
		localparam sym_t E0 = expected_sym(state_t'(P0), IN_B);
		localparam sym_t E1 = expected_sym(state_t'(P1), IN_B);

		pm_t sum0;
		pm_t sum1;
		logic sel;

		// add
		assign sum0 = pm_rd[P0] + pm_t'(d_tab[E0]);
		assign sum1 = pm_rd[P1] + pm_t'(d_tab[E1]);
		// compare, ties go to p0
		assign sel = (sum1 < sum0);
		// select
		assign pm_nxt[gs]  = sel ? sum1 : sum0;
		assign dec_nxt[gs] = sel;
	end

	//////////////////////////////
	// registers
	//////////////////////////////

	// decision strobe follows bm_valid by one cycle
	always_ff @(posedge clk)
	begin
		if (frame_rst)
			dec_valid <= 1'b0;
		else
			dec_valid <= bm_valid;
	end

	// metrics and decisions
	always_ff @(posedge clk)
	begin
		if (bm_valid)
		begin
			for (int i = 0; i < `VIT_STATES; i++)
				pm_q[i] <= pm_nxt[i];
			dec <= dec_nxt;
		end
	end

endmodule

//--- hw/traceback.sv
`timescale 1ns/1ps
`include "vit_cfg.svh"

module traceback import vit_pkg::*; (
	input  logic     clk,
	input  logic     frame_rst,
	input  logic     in_valid,
	input  logic     dec_valid,
	input  dec_vec_t dec,
	output logic     acc_ready,
	output logic     out_valid,
	input  logic     out_ready,
	output logic     out_bit
);

	localparam sym_idx_t LAST_SYM = sym_idx_t'(`VIT_FRAME_LEN - 1);
	localparam sym_idx_t LAST_BIT = sym_idx_t'(`VIT_INFO_LEN - 1);

	tb_state_e tb_state;
	// write, trace and emit index
	sym_idx_t  pos;
	// accepted input symbols of this frame
	sym_idx_t  acc_cnt;
	state_t    cur_state;
	logic      in_done;
	logic      in_done_nxt;
	logic      acc_xfer;
	logic      out_xfer;
	logic      cur_dec;

	// survivor memory and decoded bits
	dec_vec_t               dec_mem [0:`VIT_FRAME_LEN-1];
	logic [`VIT_INFO_LEN-1:0] bit_buf;

	assign acc_xfer = in_valid & acc_ready;
	assign out_xfer = out_valid & out_ready;

	// decision of the current state at the current position
	assign cur_dec = dec_mem[pos][cur_state];

	//////////////////////////////
	// input gating
	//////////////////////////////

	// frame input complete after the last symbol
	// open again once the last bit has left
	always_comb
	begin
		in_done_nxt = in_done;
		if (acc_xfer && acc_cnt == LAST_SYM)
			in_done_nxt = 1'b1;
		if (out_xfer && pos == LAST_BIT)
			in_done_nxt = 1'b0;
	end

	//////////////////////////////
	// fsm
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (frame_rst)
		begin
			tb_state  <= TB_COLLECT;
			pos       <= '0;
			acc_cnt   <= '0;
			cur_state <= '0;
			in_done   <= 1'b0;
			acc_ready <= 1'b0;
		end
		else
		begin
			in_done   <= in_done_nxt;
			acc_ready <= ~in_done_nxt;
			if (acc_xfer)
			begin
				if (acc_cnt == LAST_SYM)
					acc_cnt <= '0;
				else
					acc_cnt <= acc_cnt + sym_idx_t'(1);
			end
			case (tb_state)
				TB_COLLECT:
				begin
					// last decision written, trace from state 0
					if (dec_valid)
					begin
						if (pos == LAST_SYM)
						begin
							tb_state  <= TB_TRACE;
							cur_state <= '0;
						end
						else
							pos <= pos + sym_idx_t'(1);
					end
				end
				TB_TRACE:
				begin
					// step to the winning predecessor
					cur_state <= {cur_state[`VIT_NU-2:0], cur_dec};
					if (pos == '0)
						tb_state <= TB_EMIT;
					else
						pos <= pos - sym_idx_t'(1);
				end
				TB_EMIT:
				begin
					if (out_xfer)
					begin
						if (pos == LAST_BIT)
						begin
							tb_state <= TB_COLLECT;
							pos      <= '0;
						end
						else
							pos <= pos + sym_idx_t'(1);
					end
				end
				default:
					tb_state <= TB_COLLECT;
			endcase
		end
	end

	//////////////////////////////
	// storage
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (tb_state == TB_COLLECT && dec_valid)
			dec_mem[pos] <= dec;
		// top bit of the state is the input bit, tail bits dropped
		if (tb_state == TB_TRACE && pos <= LAST_BIT)
			bit_buf[pos[`VIT_INFO_LOG-1:0]] <= cur_state[`VIT_NU-1];
	end

	// output stream, held until taken
	assign out_valid = (tb_state == TB_EMIT);
	assign out_bit   = bit_buf[pos[`VIT_INFO_LOG-1:0]];

endmodule

//--- hw/viterbi_top.sv
`timescale 1ns/1ps
`include "vit_cfg.svh"

module viterbi_top import vit_pkg::*; (
	input  logic clk,
	input  logic frame_rst,
	input  logic in_valid,
	output logic in_ready,
	input  sym_t in_sym,
	output logic out_valid,
	input  logic out_ready,
	output logic out_bit
);

	// branch metric to acs
	logic     bm_valid;
	logic     bm_first;
	dist_t    d00;
	dist_t    d01;
	dist_t    d10;
	dist_t    d11;
	// acs to traceback
	logic     dec_valid;
	dec_vec_t dec;
	// input handshake owned by traceback
	logic     acc_ready;

	assign in_ready = acc_ready;

	//////////////////////////////
	// decode
	//////////////////////////////

	branch_metric u_bm (
		.clk       (clk),
		.frame_rst (frame_rst),
		.in_valid  (in_valid),
		.in_ready  (acc_ready),
		.in_sym    (in_sym),
		.bm_valid  (bm_valid),
		.bm_first  (bm_first),
		.d00       (d00),
		.d01       (d01),
		.d10       (d10),
		.d11       (d11)
	);

	//////////////////////////////
	// execute
	//////////////////////////////

	acs_array u_acs (
		.clk       (clk),
		.frame_rst (frame_rst),
		.bm_valid  (bm_valid),
		.bm_first  (bm_first),
		.d00       (d00),
		.d01       (d01),
		.d10       (d10),
		.d11       (d11),
		.dec_valid (dec_valid),
		.dec       (dec)
	);

	//////////////////////////////
	// result
	//////////////////////////////

	// sees in_valid to close the input after the last symbol
	traceback u_tb (
		.clk       (clk),
		.frame_rst (frame_rst),
		.in_valid  (in_valid),
		.dec_valid (dec_valid),
		.dec       (dec),
		.acc_ready (acc_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_bit   (out_bit)
	);

endmodule

//--- test/tb_viterbi_tasks.svh
// one cycle up to the drive point after the rising edge
task automatic next_cycle();
	@(posedge clk);
	#DRV_DLY;
endtask

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_sym_idx(input string name, input sym_idx_t got, input sym_idx_t exp);
	if (got !== exp)
	begin
		$display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		abort_run();
	end
endtask

//////////////////////////////
// drive and collect
//////////////////////////////

task automatic apply_reset(input int n_cyc);
	frame_rst = 1'b1;
	in_valid  = 1'b0;
	out_ready = 1'b0;
	repeat (n_cyc) next_cycle();
	// both handshakes closed while in reset
	check_bit("out_valid", out_valid, 1'b0);
	check_bit("in_ready", in_ready, 1'b0);
	frame_rst = 1'b0;
	next_cycle();
	// input open again one cycle after reset
	check_bit("out_valid", out_valid, 1'b0);
	check_bit("in_ready", in_ready, 1'b1);
endtask

// reference encoder with register of new bit then old state
task automatic build_frame(input logic [`VIT_INFO_LEN-1:0] info, input int n_flips);
	state_t                      st;
	logic                        b;
	logic [`VIT_K-1:0]           enc;
	logic [2*`VIT_FRAME_LEN-1:0] flip_mask;
	int                          pos;
	int                          done;
	st      = '0;
	tx_info = info;
	for (int i = 0; i < `VIT_FRAME_LEN; i++)
	begin
		// zero tail after the info bits
		b         = (i < `VIT_INFO_LEN) ? info[i] : 1'b0;
		enc       = {b, st};
		tx_sym[i] = {^(enc & `VIT_G0), ^(enc & `VIT_G1)};
		st        = enc[`VIT_K-1:1];
	end
	// channel errors at distinct bit positions
	flip_mask = '0;
	done      = 0;
	while (done < n_flips)
	begin
		pos = int'($urandom_range(2 * `VIT_FRAME_LEN - 1, 0));
		if (!flip_mask[pos])
		begin
			flip_mask[pos]         = 1'b1;
			tx_sym[pos/2][pos%2] = ~tx_sym[pos/2][pos%2];
			done++;
		end
	end
endtask

task automatic send_syms(input int n_syms, input logic gaps);
	logic xfer;
	int   gap;
	for (int i = 0; i < n_syms; i++)
	begin
		gap = gaps ? int'($urandom_range(2, 0)) : 0;
		in_valid = 1'b0;
		repeat (gap) next_cycle();
		in_valid = 1'b1;
		in_sym   = tx_sym[i];
		// held until taken
		xfer = 1'b0;
		while (!xfer)
		begin
			xfer = in_ready;
			next_cycle();
		end
	end
	in_valid = 1'b0;
endtask

// gathers bits until the input opens again
// probe keeps in_valid high to show no symbol is taken meanwhile
task automatic collect_bits(input logic rand_ready, input logic probe);
	logic held;
	logic held_bit;
	rx_cnt   = 0;
	held     = 1'b0;
	held_bit = 1'b0;
	in_valid = probe;
	in_sym   = sym_t'($urandom_range(3, 0));
	while (!in_ready)
	begin
		// stalled bit stays put
		if (held)
		begin
			check_bit("out_valid", out_valid, 1'b1);
			check_bit("out_bit", out_bit, held_bit);
		end
		out_ready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
		if (out_valid && out_ready)
		begin
			if (rx_cnt >= `VIT_INFO_LEN)
			begin
				$display("more than %0d output bits in one frame", `VIT_INFO_LEN);
				abort_run();
			end
			rx_bits[rx_cnt] = out_bit;
			rx_cnt++;
		end
		held     = out_valid & ~out_ready;
		held_bit = out_bit;
		next_cycle();
		if (out_valid && in_ready)
		begin
			$display("in_ready went high while a frame was still being emitted");
			abort_run();
		end
	end
	in_valid  = 1'b0;
	out_ready = 1'b0;
endtask

task automatic check_frame();
	check_sym_idx("output bit count", sym_idx_t'(rx_cnt), sym_idx_t'(`VIT_INFO_LEN));
	for (int i = 0; i < `VIT_INFO_LEN; i++)
		check_bit($sformatf("out_bit[%0d]", i), rx_bits[i], tx_info[i]);
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic test_zero_frame();
	build_frame('0, 0);
	send_syms(`VIT_FRAME_LEN, 1'b0);
	collect_bits(1'b0, 1'b0);
	check_frame();
endtask

task automatic test_random_frames();
	logic [`VIT_INFO_LEN-1:0] info_word;
	repeat (6)
	begin
		info_word = $urandom();
		build_frame(info_word, 0);
		send_syms(`VIT_FRAME_LEN, 1'b1);
		collect_bits(1'b0, 1'b1);
		check_frame();
	end
endtask

// free distance 10 corrects up to 4 errors
task automatic test_bit_errors();
	logic [`VIT_INFO_LEN-1:0] info_word;
	for (int n = 1; n <= 4; n++)
	begin
		repeat (2)
		begin
			info_word = $urandom();
			build_frame(info_word, n);
			send_syms(`VIT_FRAME_LEN, 1'b1);
			collect_bits(1'b0, 1'b0);
			check_frame();
		end
	end
endtask

task automatic test_backpressure();
	logic [`VIT_INFO_LEN-1:0] info_word;
	repeat (4)
	begin
		info_word = $urandom();
		build_frame(info_word, int'($urandom_range(2, 0)));
		send_syms(`VIT_FRAME_LEN, 1'b0);
		collect_bits(1'b1, 1'b1);
		check_frame();
	end
endtask

task automatic test_mid_frame_reset();
	logic [`VIT_INFO_LEN-1:0] info_word;
	// reset during output
	info_word = $urandom();
	build_frame(info_word, 0);
	send_syms(`VIT_FRAME_LEN, 1'b0);
	while (!out_valid)
		next_cycle();
	out_ready = 1'b1;
	repeat (5) next_cycle();
	apply_reset(3);
	// reset during input
	send_syms(17, 1'b1);
	apply_reset(3);
	// clean frame afterwards
	info_word = $urandom();
	build_frame(info_word, 2);
	send_syms(`VIT_FRAME_LEN, 1'b1);
	collect_bits(1'b1, 1'b0);
	check_frame();
endtask

//--- test/tb_viterbi.sv
`timescale 1ns/1ps
`include "vit_cfg.svh"

module tb_viterbi import vit_pkg::*; ();

	localparam int SEED     = 97622;
	localparam int DRV_DLY  = 1;
	localparam int N_FRAMES = 22;
	// 2000 cycles for every frame of the run
	localparam int WATCHDOG_CYC = 2000 * N_FRAMES;

	logic clk;
	logic frame_rst;
	logic in_valid;
	logic in_ready;
	sym_t in_sym;
	logic out_valid;
	logic out_ready;
	logic out_bit;

	// current frame, as sent and as received
	logic [`VIT_INFO_LEN-1:0] tx_info;
	sym_t tx_sym [`VIT_FRAME_LEN];
	logic rx_bits [`VIT_INFO_LEN];
	int   rx_cnt;

	viterbi_top u_dut (
		.clk       (clk),
		.frame_rst (frame_rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_sym    (in_sym),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_bit   (out_bit)
	);

	// end of the run on the first error
	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_viterbi_tasks.svh"

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////
	// watchdog
	//////////////////////////////

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYC);
		abort_run();
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial
	begin
		$timeformat(-9, 1, " ns", 0);
		void'($urandom(SEED));
		frame_rst = 1'b1;
		in_valid  = 1'b0;
		in_sym    = '0;
		out_ready = 1'b0;
		apply_reset(10);
		test_zero_frame();
		test_random_frames();
		test_bit_errors();
		test_backpressure();
		test_mid_frame_reset();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+hw
+incdir+test
hw/vit_pkg.sv
hw/branch_metric.sv
hw/acs_array.sv
hw/traceback.sv
hw/viterbi_top.sv
test/tb_viterbi.sv

//--- Makefile
TOP := tb_viterbi

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
